// File: bench/mnist_sequencer_assert.sv
`timescale 1ns/1ps
`include "seq_consts.svh"

module mnist_sequencer_assert (
    input logic               i_CLK,
    input logic               i_RST_n,
    input logic               i_doneled,
    input logic               i_pb_we,
    input logic [`BUF_AW-1:0] i_pb_addr,
    input logic [`BUF_AW-1:0] i_pa_addr
);

    // failure counts per property
    int doneled_fails  = 0;
    int pb_addr_fails  = 0;
    int pa_range_fails = 0;

    // led stays lit until reset
    a_doneled_held: assert property (@(posedge i_CLK) disable iff (!i_RST_n)
        i_doneled |=> i_doneled)
        else begin
            $error("o_DONELED fell after it was lit");
            doneled_fails++;
        end

    // only the three image words and the two result words are written
    a_pb_addr: assert property (@(posedge i_CLK) disable iff (!i_RST_n)
        i_pb_we |-> (i_pb_addr inside {`BUF_IMG_ADDR0, `BUF_IMG_ADDR1, `BUF_IMG_ADDR2,
                                       `BUF_L1_ADDR, `BUF_L2_ADDR}))
        else begin
            $error("port B write at address %0d", i_pb_addr);
            pb_addr_fails++;
        end

    a_pa_range: assert property (@(posedge i_CLK) disable iff (!i_RST_n)
        i_pa_addr <= `L3_W_LAST)
        else begin
            $error("port A address %0d beyond the last weight", i_pa_addr);
            pa_range_fails++;
        end

endmodule

bind mnist_sequencer mnist_sequencer_assert u_seq_assert (
    .i_CLK     (i_CLK),
    .i_RST_n   (i_RST_n),
    .i_doneled (o_DONELED),
    .i_pb_we   (o_WEIGHTROM_PB_WE),
    .i_pb_addr (o_WEIGHTROM_PB_ADDR),
    .i_pa_addr (o_WEIGHTROM_PA_ADDR)
);

// File: bench/seq_stimulus.txt
// one 32-bit hex word per line; the comment after a word names its field
// run parameters, port b write order, port a sweeps, word mask, data offsets
00000002 // image count
0000000a // image rom address width
00000004 // idle cycles before the start press
000003c0 // port b write 1, image word 0
000003c1 // port b write 2, image word 1
000003c2 // port b write 3, image word 2
00000398 // port b write 4, layer 1 result
00000399 // port b write 5, layer 2 result
00000000 // layer 1 first weight
000002ff // layer 1 last weight
00000300 // layer 2 first weight
0000037f // layer 2 last weight
00000380 // layer 3 first weight
00000389 // layer 3 last weight
0000fff0 // word mask of the last line
00000000 // offset pulse 1
00000016 // offset pulse 2
0000001c // offset pulse 3
00000000 // offset pulse 4

// File: bench/tb_mnist_sequencer.sv
`timescale 1ns/1ps

module tb_mnist_sequencer;

    // must agree with the first two words of the stimulus file
    localparam int IMGNUM       = 2;
    localparam int IAW          = 10;
    localparam int STIM_WORDS   = 19;
    localparam int IMG_TIMEOUT  = 2000;
    localparam int DONE_TIMEOUT = 200;

    // word positions in the stimulus file
    localparam int S_IMGNUM = 0;
    localparam int S_IAW    = 1;
    localparam int S_PRESS  = 2;
    localparam int S_WR     = 3;
    localparam int S_SWEEP  = 8;
    localparam int S_MASK   = 14;
    localparam int S_OFS    = 15;

    logic           i_CLK;
    logic           i_RST_n;
    logic           i_STARTSW;
    logic           o_DONELED;
    logic [IAW-1:0] o_IMGROM_ADDR;
    logic           o_IMGROM_RST;
    logic           o_IMGROM_HOLD;
    logic [4:0]     o_IMGROM_DATA_OFFSET;
    logic           o_IMGROM_DATA_OFFSET_WE;
    logic [9:0]     o_WEIGHTROM_PA_ADDR;
    logic [9:0]     o_WEIGHTROM_PB_ADDR;
    logic           o_WEIGHTROM_PB_WE;
    logic           o_SR_WORD_RST;
    logic           o_SR_WORD_WE;
    logic [15:0]    o_SR_WORD_MASK;
    logic           o_SR_CHAIN_RST;
    logic           o_SR_CHAIN_SHIFT;
    logic           o_ACC_RST;
    logic           o_ACC_EN;
    logic           o_ACCVAL_LD;
    logic           o_COEFF_SEL;

    logic [31:0]    stim [0:STIM_WORDS-1];
    int             wr_cnt;
    int             ofs_cnt;
    int             mask_cnt;
    int             lay;
    int             cycles;
    int             addr_steps;
    logic           pend;
    logic [IAW-1:0] img_addr;

    mnist_sequencer #(.IAW(IAW), .IMGNUM(IMGNUM)) i_dut (.*);

    initial begin
        i_CLK = 1'b0;
        forever #4 i_CLK = ~i_CLK;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns %s got %0d expected %0d", $time, name, got, exp);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    function automatic int assert_failures();
        return i_dut.u_seq_assert.doneled_fails + i_dut.u_seq_assert.pb_addr_fails +
               i_dut.u_seq_assert.pa_range_fails;
    endfunction

    always @(negedge i_CLK) begin
        if (assert_failures() != 0) begin
            $display("a bound assertion failed, see the error lines above");
            $display("Done: errors found");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // per-cycle monitor sampled at the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic monitor_cycle();
        logic [31:0]    lo;
        logic [31:0]    hi;
        logic [IAW-1:0] next_addr;
        if (o_WEIGHTROM_PB_WE) begin
            if (wr_cnt == 0)
                check_value("layer 3 start seen", pend, 0);
            check_value("o_WEIGHTROM_PB_ADDR", o_WEIGHTROM_PB_ADDR, stim[S_WR + wr_cnt]);
            wr_cnt++;
            // image writes 3 to 5 open layers 1 to 3
            lay  = (wr_cnt >= 3) ? wr_cnt - 2 : 0;
            pend = (wr_cnt >= 3);
        end
        if (o_IMGROM_DATA_OFFSET_WE) begin
            check_value("o_IMGROM_DATA_OFFSET", o_IMGROM_DATA_OFFSET,
                        stim[S_OFS + ofs_cnt % 4]);
            ofs_cnt++;
        end
        if (o_SR_WORD_MASK != '0) begin
            check_value("o_SR_WORD_MASK", o_SR_WORD_MASK, stim[S_MASK]);
            mask_cnt++;
        end
        // the image rom address only ever steps forward by one
        next_addr = img_addr + 1'b1;
        if (o_IMGROM_ADDR !== img_addr) begin
            check_value("o_IMGROM_ADDR", o_IMGROM_ADDR, next_addr);
            addr_steps++;
        end
        img_addr = o_IMGROM_ADDR;
        if (lay != 0) begin
            lo = stim[S_SWEEP + 2 * (lay - 1)];
            hi = stim[S_SWEEP + 2 * (lay - 1) + 1];
            // first address inside the new range must be the first weight
            if (pend && o_WEIGHTROM_PA_ADDR >= lo && o_WEIGHTROM_PA_ADDR <= hi) begin
                check_value("o_WEIGHTROM_PA_ADDR at layer start", o_WEIGHTROM_PA_ADDR, lo);
                pend = 1'b0;
            end
            if (o_WEIGHTROM_PA_ADDR > hi)
                check_value("o_WEIGHTROM_PA_ADDR", o_WEIGHTROM_PA_ADDR, hi);
            if (lay == 1)
                check_value("o_COEFF_SEL", o_COEFF_SEL, 0);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        i_RST_n   <= 1'b0;
        i_STARTSW <= 1'b0;
        wr_cnt     = 0;
        ofs_cnt    = 0;
        mask_cnt   = 0;
        lay        = 0;
        addr_steps = 0;
        pend       = 1'b0;
        $readmemh("bench/seq_stimulus.txt", stim);
        check_value("stimulus image count", stim[S_IMGNUM], IMGNUM);
        check_value("stimulus address width", stim[S_IAW], IAW);

        repeat (2) @(posedge i_CLK);
        i_RST_n <= 1'b1;

        // idle outputs before the press
        repeat (stim[S_PRESS]) begin
            @(negedge i_CLK);
            check_value("o_DONELED", o_DONELED, 0);
            check_value("o_WEIGHTROM_PB_WE", o_WEIGHTROM_PB_WE, 0);
            check_value("o_SR_WORD_WE", o_SR_WORD_WE, 0);
            check_value("o_SR_CHAIN_SHIFT", o_SR_CHAIN_SHIFT, 0);
            check_value("o_ACC_EN", o_ACC_EN, 0);
            check_value("o_IMGROM_RST", o_IMGROM_RST, 1);
            check_value("o_IMGROM_HOLD", o_IMGROM_HOLD, 1);
            check_value("o_ACC_RST", o_ACC_RST, 1);
            img_addr = o_IMGROM_ADDR;
        end
        @(posedge i_CLK);
        i_STARTSW <= 1'b1;
        @(posedge i_CLK);
        i_STARTSW <= 1'b0;

        for (int img = 0; img < IMGNUM; img++) begin
            wr_cnt     = 0;
            cycles     = 0;
            addr_steps = 0;
            while (wr_cnt < 5) begin
                if (cycles >= IMG_TIMEOUT) begin
                    $display("timeout: image %0d saw only %0d port B writes", img, wr_cnt);
                    $display("Done: errors found");
                    $fatal(1);
                end
                @(negedge i_CLK);
                monitor_cycle();
                check_value("o_DONELED", o_DONELED, 0);
                cycles++;
            end
            if (addr_steps == 0) begin
                $display("image %0d did not advance the image rom address", img);
                $display("Done: errors found");
                $fatal(1);
            end
            check_value("offset pulse count", ofs_cnt, 4 * (img + 1));
            check_value("mask pulse count", mask_cnt, img + 1);
        end

        // led after the last image and no writes from here on
        cycles = 0;
        while (!o_DONELED) begin
            if (cycles >= DONE_TIMEOUT) begin
                $display("timeout: o_DONELED did not rise after the last image");
                $display("Done: errors found");
                $fatal(1);
            end
            @(negedge i_CLK);
            check_value("o_WEIGHTROM_PB_WE", o_WEIGHTROM_PB_WE, 0);
            monitor_cycle();
            cycles++;
        end
        check_value("layer 3 start seen", pend, 0);
        repeat (50) begin
            @(negedge i_CLK);
            check_value("o_WEIGHTROM_PB_WE", o_WEIGHTROM_PB_WE, 0);
            check_value("o_DONELED", o_DONELED, 1);
        end

        if (assert_failures() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("%0d assertion failures during the run", assert_failures());
            $display("Done: errors found");
            $fatal(1);
        end
    end

endmodule

// File: hdl/control_merge.sv
`timescale 1ns/1ps

module control_merge (
    input  logic             i_CLK,
    input  logic             i_RST_n,
    input  seq_pkg::pf_ctl_t i_pf,
    input  seq_pkg::ly_ctl_t i_ly,
    output seq_pkg::sr_ctl_t o_sr,
    output seq_pkg::port_b_t o_pb
);

    always_ff @(posedge i_CLK) begin
        if (!i_RST_n) begin
            o_sr <= '0;
            o_pb <= '0;
        end else begin
            // resets come from either side
            o_sr.word_rst  <= i_pf.sr.word_rst | i_ly.word_rst;
            o_sr.chain_rst <= i_pf.sr.chain_rst | i_ly.chain_rst;
            // word write, mask and shift are prefetch only
            o_sr.word_we   <= i_pf.sr.word_we;
            o_sr.word_mask <= i_pf.sr.word_mask;
            o_sr.shift     <= i_pf.sr.shift;

            // prefetch owns port b while it runs
            o_pb.addr <= i_pf.active ? i_pf.pb.addr : i_ly.pb.addr;
            o_pb.we   <= i_pf.pb.we | i_ly.pb.we;
        end
    end

endmodule

// File: hdl/image_prefetch.sv
`timescale 1ns/1ps
`include "seq_consts.svh"

module image_prefetch #(
    parameter int IAW = 10
) (
    input  logic                 i_CLK,
    input  logic                 i_RST_n,
    input  logic                 i_start,
    output logic                 o_done,
    output logic [IAW-1:0]       o_img_addr,
    output seq_pkg::imgrom_ctl_t o_imgrom,
    output seq_pkg::pf_ctl_t     o_pf
);

    import seq_pkg::*;

    logic       run;
    logic [5:0] cyc;
    sr_ctl_t    sr_q;
    port_b_t    pb_q;

    // run bit doubles as port b ownership for the merge
    assign o_pf = '{sr: sr_q, pb: pb_q, active: run};

    //////////////////////////////////////////////////////////////////////
    // cycle-counted strobes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_CLK) begin
        if (!i_RST_n || !run) begin
            run                <= i_RST_n && i_start;
            o_done             <= 1'b0;
            cyc                <= `PF_CYCLES_LAST;
            o_imgrom.rst       <= 1'b1;
            o_imgrom.hold      <= 1'b1;
            o_imgrom.offset    <= '0;
            o_imgrom.offset_we <= 1'b0;
            sr_q               <= '0;
            pb_q               <= '0;
        end else begin
            // held one cycle past done so the 962 write keeps port b
            run    <= !o_done;
            o_done <= (cyc == `PF_DONE_CYC);
            cyc    <= (cyc == `PF_CYCLES_LAST) ? 6'd0 : cyc + 6'd1;

            o_imgrom.rst  <= (cyc == 6'd0) || (cyc >= `PF_MASK_CYC);
            o_imgrom.hold <= (cyc == `PF_HOLD_CYC);

            sr_q.word_rst  <= (cyc == 6'd0);
            sr_q.chain_rst <= (cyc == `PF_CHAIN_RST_CYC);
            sr_q.word_mask <= (cyc == `PF_MASK_CYC) ? `PF_MASK_VALUE : '0;
            sr_q.word_we   <= (cyc == `PF_WE_ON_CYC) ? 1'b1 :
                              (cyc == `PF_DONE_CYC)  ? 1'b0 : sr_q.word_we;
            sr_q.shift     <= (cyc == `PF_SHIFT_ON_CYC) ? 1'b1 :
                              (cyc == `PF_DONE_CYC)     ? 1'b0 : sr_q.shift;

            // one buffer word per image line group
            pb_q.we <= 1'b1;
            case (cyc)
                `PF_WR_CYC0: pb_q.addr <= `BUF_IMG_ADDR0;
                `PF_WR_CYC1: pb_q.addr <= `BUF_IMG_ADDR1;
                `PF_WR_CYC2: pb_q.addr <= `BUF_IMG_ADDR2;
                default: begin
                    pb_q.we   <= 1'b0;
                    pb_q.addr <= '0;
                end
            endcase

            // offset revisions
            o_imgrom.offset_we <= 1'b1;
            case (cyc)
                6'd0:         o_imgrom.offset <= '0;
                `PF_OFS_CYC1: o_imgrom.offset <= `PF_OFS1;
                `PF_OFS_CYC2: o_imgrom.offset <= `PF_OFS2;
                `PF_DONE_CYC: o_imgrom.offset <= '0;
                default:      o_imgrom.offset_we <= 1'b0;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // image rom address
    //////////////////////////////////////////////////////////////////////

    // carries on between images, so each run reads the next image
    always_ff @(posedge i_CLK) begin
        if (!i_RST_n) begin
            o_img_addr <= '1;
        end else if (run && !o_imgrom.hold && cyc <= `PF_ADDR_STOP_CYC) begin
            o_img_addr <= o_img_addr + IAW'(1);
        end
    end

endmodule

// File: hdl/layer_sequencer.sv
`timescale 1ns/1ps
`include "seq_consts.svh"

module layer_sequencer (
    input  logic               i_CLK,
    input  logic               i_RST_n,
    input  logic               i_start,
    output logic               o_done,
    output logic [`BUF_AW-1:0] o_pa_addr,
    output seq_pkg::acc_ctl_t  o_acc,
    output seq_pkg::ly_ctl_t   o_ly
);

    import seq_pkg::*;

    logic               run;
    layer_e             layer;
    logic [`OPC_W-1:0]  opcnt;
    // weight sweep finished, waiting for write-back
    logic               stop;

    always_ff @(posedge i_CLK) begin
        if (!i_RST_n || !run) begin
            run             <= i_RST_n && i_start;
            o_done          <= 1'b0;
            layer           <= L1;
            opcnt           <= '0;
            stop            <= 1'b0;
            o_pa_addr       <= `L1_W_FIRST;
            o_ly.word_rst   <= 1'b0;
            o_ly.chain_rst  <= 1'b0;
            o_ly.pb.addr    <= `BUF_IMG_ADDR0;
            o_ly.pb.we      <= 1'b0;
            o_acc.acc_rst   <= 1'b1;
            o_acc.acc_en    <= 1'b0;
            o_acc.accval_ld <= 1'b0;
            o_acc.coeff_sel <= 1'b0;
        end else begin
            o_done         <= 1'b0;
            opcnt          <= opcnt + 1'b1;
            o_ly.pb.we     <= 1'b0;
            o_ly.word_rst  <= 1'b0;
            o_ly.chain_rst <= 1'b0;
            case (layer)
                ////////////////////////////////////////////////////////////////
                L1: begin
                    o_acc.coeff_sel <= 1'b0;
                    if (!stop) begin
                        o_pa_addr <= (o_pa_addr == `L1_W_LAST) ? `L1_W_FIRST :
                                     o_pa_addr + 1'b1;
                        // port b cycles over the three image words
                        o_ly.pb.addr <= (o_ly.pb.addr == `BUF_IMG_ADDR2) ? `BUF_IMG_ADDR0 :
                                        o_ly.pb.addr + 1'b1;
                        o_acc.acc_rst   <= 1'b0;
                        o_acc.acc_en    <= (o_ly.pb.addr[1:0] == 2'd1) ||
                                           (o_ly.pb.addr[1:0] == 2'd2);
                        o_acc.accval_ld <= (o_ly.pb.addr[1:0] == 2'd2);
                        o_ly.word_rst   <= (opcnt == '0);
                        o_ly.chain_rst  <= (opcnt == '0);
                        stop            <= (opcnt == `L1_STOP_CYC);
                    end else begin
                        o_ly.pb.addr    <= `BUF_L1_ADDR;
                        o_ly.pb.we      <= (opcnt == `L1_WR_CYC);
                        o_acc.acc_en    <= 1'b0;
                        o_acc.accval_ld <= 1'b0;
                        if (opcnt == `L1_NEXT_CYC) begin
                            layer         <= L2;
                            stop          <= 1'b0;
                            o_pa_addr     <= `L2_W_FIRST;
                            o_acc.acc_rst <= 1'b1;
                        end
                    end
                end
                ////////////////////////////////////////////////////////////////
                L2: begin
                    o_acc.coeff_sel <= 1'b1;
                    if (!stop) begin
                        o_pa_addr <= (o_pa_addr == `L2_W_LAST) ? `L2_W_FIRST :
                                     o_pa_addr + 1'b1;
                        // reads back the layer 1 word
                        o_ly.pb.addr    <= `BUF_L1_ADDR;
                        o_acc.acc_rst   <= 1'b0;
                        o_acc.accval_ld <= 1'b1;
                        o_ly.word_rst   <= (opcnt == `L2_START_CYC);
                        o_ly.chain_rst  <= (opcnt == `L2_START_CYC);
                        stop            <= (opcnt == `L2_STOP_CYC);
                    end else begin
                        o_ly.pb.addr    <= `BUF_L2_ADDR;
                        o_ly.pb.we      <= (opcnt == `L2_WR_CYC);
                        o_acc.accval_ld <= 1'b0;
                        if (opcnt == `L2_NEXT_CYC) begin
                            layer         <= L3;
                            stop          <= 1'b0;
                            o_pa_addr     <= `L3_W_FIRST;
                            o_acc.acc_rst <= 1'b1;
                        end
                    end
                end
                ////////////////////////////////////////////////////////////////
                L3: begin
                    if (!stop) begin
                        o_pa_addr <= (o_pa_addr == `L3_W_LAST) ? `L3_W_FIRST :
                                     o_pa_addr + 1'b1;
                        o_ly.pb.addr  <= `BUF_L2_ADDR;
                        o_acc.acc_rst <= 1'b0;
                        stop          <= (opcnt == `L3_STOP_CYC);
                    end else begin
                        // back to idle once the image is finished
                        layer     <= L1;
                        o_pa_addr <= `L1_W_FIRST;
                        o_done    <= 1'b1;
                        run       <= 1'b0;
                    end
                end
                default: layer <= L1;
            endcase
        end
    end

endmodule

// File: hdl/mnist_sequencer.sv
`timescale 1ns/1ps
`include "seq_consts.svh"

module mnist_sequencer #(
    parameter int IAW    = 10,
    parameter int IMGNUM = 2
) (
    input  logic                  i_CLK,
    input  logic                  i_RST_n,
    input  logic                  i_STARTSW,
    output logic                  o_DONELED,

    // image rom
    output logic [IAW-1:0]        o_IMGROM_ADDR,
    output logic                  o_IMGROM_RST,
    output logic                  o_IMGROM_HOLD,
    output logic [`OFS_W-1:0]     o_IMGROM_DATA_OFFSET,
    output logic                  o_IMGROM_DATA_OFFSET_WE,

    // shared buffer
    output logic [`BUF_AW-1:0]    o_WEIGHTROM_PA_ADDR,
    output logic [`BUF_AW-1:0]    o_WEIGHTROM_PB_ADDR,
    output logic                  o_WEIGHTROM_PB_WE,

    // shift register
    output logic                  o_SR_WORD_RST,
    output logic                  o_SR_WORD_WE,
    output logic [`SR_MASK_W-1:0] o_SR_WORD_MASK,
    output logic                  o_SR_CHAIN_RST,
    output logic                  o_SR_CHAIN_SHIFT,

    // accumulator and post calc
    output logic                  o_ACC_RST,
    output logic                  o_ACC_EN,
    output logic                  o_ACCVAL_LD,
    output logic                  o_COEFF_SEL
);

    import seq_pkg::*;

    logic        pf_start;
    logic        pf_done;
    logic        ly_start;
    logic        ly_done;
    imgrom_ctl_t imgrom;
    pf_ctl_t     pf;
    ly_ctl_t     ly;
    acc_ctl_t    acc;
    sr_ctl_t     sr;
    port_b_t     pb;

    run_control #(.IMGNUM(IMGNUM)) u_run_control (
        .i_CLK      (i_CLK),
        .i_RST_n    (i_RST_n),
        .i_STARTSW  (i_STARTSW),
        .i_pf_done  (pf_done),
        .i_ly_done  (ly_done),
        .o_pf_start (pf_start),
        .o_ly_start (ly_start),
        .o_DONELED  (o_DONELED)
    );

    image_prefetch #(.IAW(IAW)) u_image_prefetch (
        .i_CLK      (i_CLK),
        .i_RST_n    (i_RST_n),
        .i_start    (pf_start),
        .o_done     (pf_done),
        .o_img_addr (o_IMGROM_ADDR),
        .o_imgrom   (imgrom),
        .o_pf       (pf)
    );

    layer_sequencer u_layer_sequencer (
        .i_CLK      (i_CLK),
        .i_RST_n    (i_RST_n),
        .i_start    (ly_start),
        .o_done     (ly_done),
        .o_pa_addr  (o_WEIGHTROM_PA_ADDR),
        .o_acc      (acc),
        .o_ly       (ly)
    );

    control_merge u_control_merge (
        .i_CLK      (i_CLK),
        .i_RST_n    (i_RST_n),
        .i_pf       (pf),
        .i_ly       (ly),
        .o_sr       (sr),
        .o_pb       (pb)
    );

    // flat outputs
    assign o_IMGROM_RST            = imgrom.rst;
    assign o_IMGROM_HOLD           = imgrom.hold;
    assign o_IMGROM_DATA_OFFSET    = imgrom.offset;
    assign o_IMGROM_DATA_OFFSET_WE = imgrom.offset_we;

    assign o_WEIGHTROM_PB_ADDR     = pb.addr;
    assign o_WEIGHTROM_PB_WE       = pb.we;

    assign o_SR_WORD_RST           = sr.word_rst;
    assign o_SR_WORD_WE            = sr.word_we;
    assign o_SR_WORD_MASK          = sr.word_mask;
    assign o_SR_CHAIN_RST          = sr.chain_rst;
    assign o_SR_CHAIN_SHIFT        = sr.shift;

    assign o_ACC_RST               = acc.acc_rst;
    assign o_ACC_EN                = acc.acc_en;
    assign o_ACCVAL_LD             = acc.accval_ld;
    assign o_COEFF_SEL             = acc.coeff_sel;

endmodule

// File: hdl/run_control.sv
`timescale 1ns/1ps

module run_control #(
    parameter int IMGNUM = 2
) (
    input  logic i_CLK,
    input  logic i_RST_n,
    input  logic i_STARTSW,
    input  logic i_pf_done,
    input  logic i_ly_done,
    output logic o_pf_start,
    output logic o_ly_start,
    output logic o_DONELED
);

    import seq_pkg::*;

    localparam int CW = $clog2(IMGNUM + 1);

    seq_state_e     state;
    logic [CW-1:0]  img_cnt;

    always_ff @(posedge i_CLK) begin
        if (!i_RST_n) begin
            state      <= RST;
            img_cnt    <= '0;
            o_pf_start <= 1'b0;
            o_ly_start <= 1'b0;
            o_DONELED  <= 1'b0;
        end else begin
            // start strobes last one cycle
            o_pf_start <= 1'b0;
            o_ly_start <= 1'b0;
            case (state)
                RST: begin
                    if (i_STARTSW) begin
                        state      <= INIT;
                        o_pf_start <= 1'b1;
                    end
                end
                INIT: begin
                    if (i_pf_done) begin
                        state      <= RUN;
                        o_ly_start <= 1'b1;
                    end
                end
                RUN: begin
                    if (i_ly_done) begin
                        img_cnt <= img_cnt + 1'b1;
                        if (img_cnt == CW'(IMGNUM - 1)) begin
                            state <= DONE;
                        end else begin
                            state      <= INIT;
                            o_pf_start <= 1'b1;
                        end
                    end
                end
                DONE: begin
                    // lit until reset
                    o_DONELED <= 1'b1;
                end
                default: state <= RST;
            endcase
        end
    end

endmodule

// File: hdl/seq_consts.svh
`ifndef SEQ_CONSTS_SVH
`define SEQ_CONSTS_SVH

// field widths
`define BUF_AW              10
`define OPC_W               10
`define SR_MASK_W           16
`define OFS_W               5

// prefetch cycle points
// the counter idles at the last count
`define PF_CYCLES_LAST      6'd54
`define PF_DONE_CYC         6'd53
`define PF_MASK_CYC         6'd52
`define PF_ADDR_STOP_CYC    6'd49
`define PF_CHAIN_RST_CYC    6'd36
`define PF_HOLD_CYC         6'd33
`define PF_SHIFT_ON_CYC     6'd3
`define PF_WE_ON_CYC        6'd2

// image word writes into the buffer
`define PF_WR_CYC0          6'd19
`define PF_WR_CYC1          6'd36
`define PF_WR_CYC2          6'd53
`define BUF_IMG_ADDR0       10'd960
`define BUF_IMG_ADDR1       10'd961
`define BUF_IMG_ADDR2       10'd962

// data offset revisions
`define PF_OFS_CYC1         6'd18
`define PF_OFS_CYC2         6'd35
`define PF_OFS1             5'd22
`define PF_OFS2             5'd28

// last line only keeps the upper twelve bits
`define PF_MASK_VALUE       16'hFFF0

// layer result words
`define BUF_L1_ADDR         10'd920
`define BUF_L2_ADDR         10'd921

// weight sweeps on port a
`define L1_W_FIRST          10'd0
`define L1_W_LAST           10'd767
`define L2_W_FIRST          10'd768
`define L2_W_LAST           10'd895
`define L3_W_FIRST          10'd896
`define L3_W_LAST           10'd905

// layer cycle points
`define L1_STOP_CYC         10'd767
`define L1_WR_CYC           10'd778
`define L1_NEXT_CYC         10'd779
`define L2_START_CYC        10'd780
`define L2_STOP_CYC         10'd907
`define L2_WR_CYC           10'd918
`define L2_NEXT_CYC         10'd920
`define L3_STOP_CYC         10'd939

`endif

// File: hdl/seq_pkg.sv
`include "seq_consts.svh"

package seq_pkg;

    typedef enum logic [1:0] {
        RST  = 2'd0,
        INIT = 2'd1,
        RUN  = 2'd2,
        DONE = 2'd3
    } seq_state_e;

    typedef enum logic [1:0] {
        L1 = 2'd0,
        L2 = 2'd1,
        L3 = 2'd2
    } layer_e;

    // shift register controls
    typedef struct packed {
        logic                   word_rst;
        logic                   word_we;
        logic [`SR_MASK_W-1:0]  word_mask;
        logic                   chain_rst;
        logic                   shift;
    } sr_ctl_t;

    // buffer port b
    typedef struct packed {
        logic [`BUF_AW-1:0]     addr;
        logic                   we;
    } port_b_t;

    typedef struct packed {
        sr_ctl_t                sr;
        port_b_t                pb;
        logic                   active;
    } pf_ctl_t;

    typedef struct packed {
        logic                   word_rst;
        logic                   chain_rst;
        port_b_t                pb;
    } ly_ctl_t;

    typedef struct packed {
        logic                   acc_rst;
        logic                   acc_en;
        logic                   accval_ld;
        logic                   coeff_sel;
    } acc_ctl_t;

    // image rom address travels beside this with IAW bits
    typedef struct packed {
        logic                   rst;
        logic                   hold;
        logic [`OFS_W-1:0]      offset;
        logic                   offset_we;
    } imgrom_ctl_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, run from the project root
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_mnist_sequencer -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "^Done: no errors$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sources.f
+incdir+hdl
hdl/seq_pkg.sv
hdl/run_control.sv
hdl/image_prefetch.sv
hdl/layer_sequencer.sv
hdl/control_merge.sv
hdl/mnist_sequencer.sv
bench/mnist_sequencer_assert.sv
bench/tb_mnist_sequencer.sv
